/* tb.f */
hw/cbuf_pkg.sv
hw/icb_reg_slice.sv
hw/cbuf_port_ctrl.sv
hw/cbuf_bank_array.sv
hw/conv_buffer.sv
verif/tb_clk_gen.sv
verif/conv_buffer_props.sv
verif/conv_buffer_tb.sv

/* Bender.yml */
package:
  name: conv_buffer

sources:
  - hw/cbuf_pkg.sv
  - hw/icb_reg_slice.sv
  - hw/cbuf_port_ctrl.sv
  - hw/cbuf_bank_array.sv
  - hw/conv_buffer.sv
  - target: test
    files:
      - verif/tb_clk_gen.sv
      - verif/conv_buffer_props.sv
      - verif/conv_buffer_tb.sv

/* verif/conv_buffer_tb.sv */
// testbench for the convolution buffer with a reference memory model and in-order checks
`timescale 1ns/1ns

module conv_buffer_tb import cbuf_pkg::*; ();

	localparam int T1_CMDS = 24;
	localparam int T2_CMDS = 32;
	localparam int T3_CMDS = 7;
	localparam int T4_CMDS = 2;
	localparam int RAND_N = 150; // per port
	localparam int T5_CMDS = BANK_N * BANK_DEPTH + 2 * RAND_N; // fill plus random
	localparam int T6_CMDS = 1;
	localparam int TOTAL_CMDS = T1_CMDS + T2_CMDS + T3_CMDS + T4_CMDS + T5_CMDS + T6_CMDS;
	localparam int WATCHDOG_CYCLES = TOTAL_CMDS * 20 + 200;

	logic aclk;
	logic rst_n;
	bank_cnt_t fmbufbankn;
	icb_cmd_t fm_cmd;
	logic fm_cmd_valid;
	logic fm_cmd_ready;
	icb_rsp_t fm_rsp;
	logic fm_rsp_valid;
	logic fm_rsp_ready;
	icb_cmd_t k_cmd;
	logic k_cmd_valid;
	logic k_cmd_ready;
	icb_rsp_t k_rsp;
	logic k_rsp_valid;
	logic k_rsp_ready;

	cbuf_data_t ref_mem [BANK_N * BANK_DEPTH]; // physical words
	icb_cmd_t fm_todo [$];
	icb_cmd_t k_todo [$];
	icb_rsp_t fm_exp [$];
	icb_rsp_t k_exp [$];

	int seed = 47782;
	int edge_cnt = 0;
	int fm_cmd_edge;
	int fm_rsp_edge;
	int err_cnt = 0;
	int check_cnt = 0;
	int test_cnt = 0;
	int test_fail = 0;
	int test_err_base = 0;
	bit bp_on = 1'b0;

	tb_clk_gen clk_gen (
		.aclk(aclk),
		.rst_n(rst_n)
	);

	conv_buffer dut (
		.aclk(aclk),
		.rst_n(rst_n),
		.fmbufbankn(fmbufbankn),
		.fm_cmd(fm_cmd),
		.fm_cmd_valid(fm_cmd_valid),
		.fm_cmd_ready(fm_cmd_ready),
		.fm_rsp(fm_rsp),
		.fm_rsp_valid(fm_rsp_valid),
		.fm_rsp_ready(fm_rsp_ready),
		.k_cmd(k_cmd),
		.k_cmd_valid(k_cmd_valid),
		.k_cmd_ready(k_cmd_ready),
		.k_rsp(k_rsp),
		.k_rsp_valid(k_rsp_valid),
		.k_rsp_ready(k_rsp_ready)
	);

	// address map and bound rule applied to the reference memory
	function automatic icb_rsp_t expected_rsp(input bit region, input icb_cmd_t cmd,
			input bank_cnt_t nfm);
		logic [31-WORD_ADDR_LSB:0] lword;
		int base;
		int size;
		int pword;
		icb_rsp_t r;
		lword = cmd.addr[31:WORD_ADDR_LSB];
		base = region ? int'(nfm) * BANK_DEPTH : 0;
		size = region ? (BANK_N - int'(nfm)) * BANK_DEPTH : int'(nfm) * BANK_DEPTH;
		r = '0;
		if (lword >= size) begin
			r.err = 1'b1; // zero data, memory untouched
			return r;
		end
		pword = base + int'(lword);
		if (cmd.read)
			r.rdata = ref_mem[pword];
		else begin
			for (int i = 0; i < LANE_BYTES; i++) begin
				if (cmd.wmask[i])
					ref_mem[pword][i*8 +: 8] = cmd.wdata[i*8 +: 8];
			end
		end
		return r;
	endfunction

	function automatic cbuf_data_t pattern_word(input int word, input int tag);
		return {8'(tag), 24'(word), 32'(word) * 32'h9e37_79b9 + 32'(tag)};
	endfunction

	function automatic icb_cmd_t make_cmd(input bit read, input icb_addr_t addr,
			input cbuf_mask_t mask, input cbuf_data_t data);
		icb_cmd_t c;
		c.addr = addr;
		c.read = read;
		c.wdata = data;
		c.wmask = mask;
		return c;
	endfunction

	function automatic icb_cmd_t random_cmd(input int word);
		icb_cmd_t c;
		c.addr = icb_addr_t'(word * LANE_BYTES) | icb_addr_t'($random(seed) & 7); // junk low bits
		c.read = 1'($random(seed));
		c.wdata = {$random(seed), $random(seed)};
		c.wmask = cbuf_mask_t'($random(seed));
		return c;
	endfunction

	task automatic check_rsp(input string name, input icb_rsp_t got, input icb_rsp_t exp);
		check_cnt++;
		if (got !== exp) begin
			err_cnt++;
			$display("Fail at %0t: %s got rdata=%h err=%b, expected rdata=%h err=%b",
				$time, name, got.rdata, got.err, exp.rdata, exp.err);
		end
	endtask

	task automatic check_ready(input string name, input bit got, input bit exp);
		check_cnt++;
		if (got !== exp) begin
			err_cnt++;
			$display("Fail at %0t: %s got %b, expected %b", $time, name, got, exp);
		end
	endtask

	task automatic check_latency(input string name, input int got, input int exp);
		check_cnt++;
		if (got != exp) begin
			err_cnt++;
			$display("Fail at %0t: %s got %0d cycles, expected %0d", $time, name, got, exp);
		end
	endtask

	// sends the queued commands of one port back to back, called on a rising edge
	task automatic drive_cmds(input bit region);
		icb_cmd_t c;
		bit taken;
		while ((region ? k_todo.size() : fm_todo.size()) != 0) begin
			if (region) begin
				c = k_todo.pop_front();
				k_cmd <= c;
				k_cmd_valid <= 1'b1;
			end else begin
				c = fm_todo.pop_front();
				fm_cmd <= c;
				fm_cmd_valid <= 1'b1;
			end
			taken = 1'b0;
			while (!taken) begin
				@(posedge aclk);
				taken = region ? k_cmd_ready : fm_cmd_ready;
			end
			if (region)
				k_exp.push_back(expected_rsp(region, c, fmbufbankn));
			else begin
				fm_exp.push_back(expected_rsp(region, c, fmbufbankn));
				fm_cmd_edge = edge_cnt;
			end
		end
		if (region)
			k_cmd_valid <= 1'b0;
		else
			fm_cmd_valid <= 1'b0;
	endtask

	task automatic wait_idle();
		while (fm_exp.size() != 0 || k_exp.size() != 0)
			@(posedge aclk);
		@(posedge aclk);
	endtask

	task automatic run_ports();
		fork
			drive_cmds(1'b0);
			drive_cmds(1'b1);
		join
		wait_idle();
	endtask

	task automatic take_rsp(input bit region);
		icb_rsp_t want;
		if ((region ? k_exp.size() : fm_exp.size()) == 0) begin
			err_cnt++;
			$display("Response on the %s port at %0t with no command outstanding",
				region ? "kernel" : "feature-map", $time);
			return;
		end
		if (region) begin
			want = k_exp.pop_front();
			check_rsp("k_rsp", k_rsp, want);
		end else begin
			want = fm_exp.pop_front();
			check_rsp("fm_rsp", fm_rsp, want);
		end
	endtask

	task automatic end_test(input string name);
		test_cnt++;
		if (err_cnt == test_err_base)
			$display("test %0d %s: ok", test_cnt, name);
		else begin
			test_fail++;
			$display("test %0d %s: %0d errors", test_cnt, name, err_cnt - test_err_base);
		end
		test_err_base = err_cnt;
	endtask

	// responses are compared in order as they transfer
	always @(posedge aclk) begin
		edge_cnt <= edge_cnt + 1;
		if (rst_n && fm_rsp_valid && fm_rsp_ready) begin
			fm_rsp_edge = edge_cnt;
			take_rsp(1'b0);
		end
		if (rst_n && k_rsp_valid && k_rsp_ready)
			take_rsp(1'b1);
	end

	always @(posedge aclk) begin
		if (bp_on) begin
			fm_rsp_ready <= 1'($random(seed));
			k_rsp_ready <= 1'($random(seed));
		end
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge aclk);
		$display("Timeout: the run did not end within %0d cycles", WATCHDOG_CYCLES);
		$display("Simulation failed");
		$finish;
	end

	initial begin
		int w;
		fmbufbankn = bank_cnt_t'(4);
		fm_cmd = '0;
		fm_cmd_valid = 1'b0;
		fm_rsp_ready = 1'b1;
		k_cmd = '0;
		k_cmd_valid = 1'b0;
		k_rsp_ready = 1'b1;
		@(posedge rst_n);
		@(posedge aclk);

		check_ready("fm_cmd_ready", fm_cmd_ready, 1'b1);
		check_ready("k_cmd_ready", k_cmd_ready, 1'b1);
		check_ready("fm_rsp_valid", fm_rsp_valid, 1'b0);
		check_ready("k_rsp_valid", k_rsp_valid, 1'b0);
		for (int i = 0; i < 8; i++)
			fm_todo.push_back(make_cmd(1'b0, 32'(i * LANE_BYTES), 8'hff, pattern_word(i, 1)));
		for (int i = 0; i < 8; i++)
			fm_todo.push_back(make_cmd(1'b0, 32'(i * LANE_BYTES), cbuf_mask_t'(8'ha5 >> i),
				~pattern_word(i, 2)));
		for (int i = 0; i < 8; i++)
			fm_todo.push_back(make_cmd(1'b1, 32'(i * LANE_BYTES), '0, '0));
		run_ports();
		end_test("reset and round trip");

		// same logical words on both ports
		for (int i = 0; i < 8; i++) begin
			fm_todo.push_back(make_cmd(1'b0, 32'(i * LANE_BYTES), 8'hff, pattern_word(i, 3)));
			k_todo.push_back(make_cmd(1'b0, 32'(i * LANE_BYTES), 8'hff, pattern_word(i, 4)));
		end
		for (int i = 0; i < 8; i++) begin
			fm_todo.push_back(make_cmd(1'b1, 32'(i * LANE_BYTES), '0, '0));
			k_todo.push_back(make_cmd(1'b1, 32'(i * LANE_BYTES), '0, '0));
		end
		run_ports();
		end_test("region separation");

		// fm word 256 aliases k word 0, k word 256 wraps onto fm word 0
		fm_todo.push_back(make_cmd(1'b0, 32'(256 * LANE_BYTES), 8'hff, pattern_word(256, 5)));
		fm_todo.push_back(make_cmd(1'b1, 32'(256 * LANE_BYTES), '0, '0));
		fm_todo.push_back(make_cmd(1'b1, 32'hffff_fff8, '0, '0));
		k_todo.push_back(make_cmd(1'b0, 32'(256 * LANE_BYTES), 8'hff, pattern_word(256, 6)));
		k_todo.push_back(make_cmd(1'b1, 32'(256 * LANE_BYTES), '0, '0));
		run_ports();
		fm_todo.push_back(make_cmd(1'b1, 32'h0, '0, '0));
		k_todo.push_back(make_cmd(1'b1, 32'h0, '0, '0));
		run_ports();
		end_test("bound check");

		k_todo.push_back(make_cmd(1'b0, 32'h0, 8'hff, pattern_word(0, 7)));
		run_ports();
		fmbufbankn <= bank_cnt_t'(6); // ports idle
		@(posedge aclk);
		fm_todo.push_back(make_cmd(1'b1, 32'(256 * LANE_BYTES), '0, '0));
		run_ports();
		end_test("remapping");

		fmbufbankn <= bank_cnt_t'(3);
		@(posedge aclk);
		for (int i = 0; i < 3 * BANK_DEPTH; i++)
			fm_todo.push_back(make_cmd(1'b0, 32'(i * LANE_BYTES), 8'hff, pattern_word(i, 8)));
		for (int i = 0; i < 5 * BANK_DEPTH; i++)
			k_todo.push_back(make_cmd(1'b0, 32'(i * LANE_BYTES), 8'hff, pattern_word(i, 9)));
		run_ports();
		for (int i = 0; i < RAND_N; i++) begin
			w = $unsigned($random(seed)) % (3 * BANK_DEPTH + 16); // a few past the bound
			fm_todo.push_back(random_cmd(w));
			w = $unsigned($random(seed)) % (5 * BANK_DEPTH + 16);
			k_todo.push_back(random_cmd(w));
		end
		@(negedge aclk);
		bp_on = 1'b1;
		@(posedge aclk);
		run_ports();
		@(negedge aclk);
		bp_on = 1'b0;
		@(posedge aclk);
		fm_rsp_ready <= 1'b1;
		k_rsp_ready <= 1'b1;
		@(posedge aclk);
		end_test("back-pressure");

		fm_todo.push_back(make_cmd(1'b1, 32'(5 * LANE_BYTES), '0, '0));
		run_ports();
		// valid rises after edge N+3 and is taken on the following edge
		check_latency("fm_rsp_valid latency", fm_rsp_edge - fm_cmd_edge - 1, 3);
		end_test("latency");

		$display("%0d tests run, %0d failed, %0d checks, %0d errors, %0d assertion failures",
			test_cnt, test_fail, check_cnt, err_cnt, dut.props.fail_cnt);
		if (err_cnt == 0 && dut.props.fail_cnt == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

/* verif/conv_buffer_props.sv */
// handshake rule checks on the convolution buffer ICB ports
`timescale 1ns/1ns

module conv_buffer_props import cbuf_pkg::*; (
	input logic     aclk,
	input logic     rst_n,
	input icb_cmd_t fm_cmd,
	input logic     fm_cmd_valid,
	input logic     fm_cmd_ready,
	input icb_rsp_t fm_rsp,
	input logic     fm_rsp_valid,
	input logic     fm_rsp_ready,
	input icb_cmd_t k_cmd,
	input logic     k_cmd_valid,
	input logic     k_cmd_ready,
	input icb_rsp_t k_rsp,
	input logic     k_rsp_valid,
	input logic     k_rsp_ready
);

	int fail_cnt = 0; // failed assertions so far

	// a raised valid holds together with its payload until the transfer
	fm_cmd_hold: assert property (@(posedge aclk) disable iff (!rst_n)
		fm_cmd_valid && !fm_cmd_ready |=> fm_cmd_valid && $stable(fm_cmd))
		else begin
			fail_cnt++;
			$error("feature-map command dropped or changed before it was taken");
		end

	k_cmd_hold: assert property (@(posedge aclk) disable iff (!rst_n)
		k_cmd_valid && !k_cmd_ready |=> k_cmd_valid && $stable(k_cmd))
		else begin
			fail_cnt++;
			$error("kernel command dropped or changed before it was taken");
		end

	fm_rsp_hold: assert property (@(posedge aclk) disable iff (!rst_n)
		fm_rsp_valid && !fm_rsp_ready |=> fm_rsp_valid && $stable(fm_rsp))
		else begin
			fail_cnt++;
			$error("feature-map response dropped or changed before it was taken");
		end

	k_rsp_hold: assert property (@(posedge aclk) disable iff (!rst_n)
		k_rsp_valid && !k_rsp_ready |=> k_rsp_valid && $stable(k_rsp))
		else begin
			fail_cnt++;
			$error("kernel response dropped or changed before it was taken");
		end

	// first cycle out of reset
	rsp_idle_after_reset: assert property (@(posedge aclk)
		$rose(rst_n) |-> !fm_rsp_valid && !k_rsp_valid)
		else begin
			fail_cnt++;
			$error("response valid raised right after reset");
		end

	cmd_ready_after_reset: assert property (@(posedge aclk)
		$rose(rst_n) |-> fm_cmd_ready && k_cmd_ready)
		else begin
			fail_cnt++;
			$error("command ready low right after reset");
		end

endmodule

bind conv_buffer conv_buffer_props props (
	.aclk(aclk),
	.rst_n(rst_n),
	.fm_cmd(fm_cmd),
	.fm_cmd_valid(fm_cmd_valid),
	.fm_cmd_ready(fm_cmd_ready),
	.fm_rsp(fm_rsp),
	.fm_rsp_valid(fm_rsp_valid),
	.fm_rsp_ready(fm_rsp_ready),
	.k_cmd(k_cmd),
	.k_cmd_valid(k_cmd_valid),
	.k_cmd_ready(k_cmd_ready),
	.k_rsp(k_rsp),
	.k_rsp_valid(k_rsp_valid),
	.k_rsp_ready(k_rsp_ready)
);

/* verif/tb_clk_gen.sv */
// testbench clock and reset source, 40 ns clock with reset held for three cycles
`timescale 1ns/1ns

module tb_clk_gen (
	output logic aclk,
	output logic rst_n
);

	localparam int PERIOD = 40;
	localparam int RST_CYCLES = 3;

	initial begin
		aclk = 1'b0;
		forever #(PERIOD / 2) aclk = ~aclk;
	end

	initial begin
		rst_n = 1'b0;
		repeat (RST_CYCLES) @(posedge aclk);
		rst_n <= 1'b1;
	end

endmodule

/* hw/conv_buffer.sv */
// convolution private buffer with feature-map and kernel ICB ports over a shared bank pool
`timescale 1ns/1ns

module conv_buffer import cbuf_pkg::*; (
	input  logic      aclk,
	input  logic      rst_n,

	input  bank_cnt_t fmbufbankn, // change only while both ports are idle

	// feature-map port
	input  icb_cmd_t  fm_cmd,
	input  logic      fm_cmd_valid,
	output logic      fm_cmd_ready,
	output icb_rsp_t  fm_rsp,
	output logic      fm_rsp_valid,
	input  logic      fm_rsp_ready,

	// kernel port
	input  icb_cmd_t  k_cmd,
	input  logic      k_cmd_valid,
	output logic      k_cmd_ready,
	output icb_rsp_t  k_rsp,
	output logic      k_rsp_valid,
	input  logic      k_rsp_ready
);

	// feature-map path between slices and controller
	icb_cmd_t fm_cmd_s;
	logic fm_cmd_s_valid;
	logic fm_cmd_s_ready;
	icb_rsp_t fm_rsp_c;
	logic fm_rsp_c_valid;
	logic fm_rsp_c_ready;
	bank_req_t fm_bank_req;
	cbuf_data_t fm_bank_rdata;

	// kernel path
	icb_cmd_t k_cmd_s;
	logic k_cmd_s_valid;
	logic k_cmd_s_ready;
	icb_rsp_t k_rsp_c;
	logic k_rsp_c_valid;
	logic k_rsp_c_ready;
	bank_req_t k_bank_req;
	cbuf_data_t k_bank_rdata;

	icb_reg_slice #(
		.payload_t(icb_cmd_t)
	) fm_cmd_slice (
		.aclk(aclk),
		.rst_n(rst_n),
		.in_data(fm_cmd),
		.in_valid(fm_cmd_valid),
		.in_ready(fm_cmd_ready),
		.out_data(fm_cmd_s),
		.out_valid(fm_cmd_s_valid),
		.out_ready(fm_cmd_s_ready)
	);

	cbuf_port_ctrl #(
		.is_kbuf(1'b0)
	) fm_ctrl (
		.aclk(aclk),
		.rst_n(rst_n),
		.fmbufbankn(fmbufbankn),
		.cmd(fm_cmd_s),
		.cmd_valid(fm_cmd_s_valid),
		.cmd_ready(fm_cmd_s_ready),
		.bank_req(fm_bank_req),
		.bank_rdata(fm_bank_rdata),
		.rsp(fm_rsp_c),
		.rsp_valid(fm_rsp_c_valid),
		.rsp_ready(fm_rsp_c_ready)
	);

	icb_reg_slice #(
		.payload_t(icb_rsp_t)
	) fm_rsp_slice (
		.aclk(aclk),
		.rst_n(rst_n),
		.in_data(fm_rsp_c),
		.in_valid(fm_rsp_c_valid),
		.in_ready(fm_rsp_c_ready),
		.out_data(fm_rsp),
		.out_valid(fm_rsp_valid),
		.out_ready(fm_rsp_ready)
	);

	icb_reg_slice #(
		.payload_t(icb_cmd_t)
	) k_cmd_slice (
		.aclk(aclk),
		.rst_n(rst_n),
		.in_data(k_cmd),
		.in_valid(k_cmd_valid),
		.in_ready(k_cmd_ready),
		.out_data(k_cmd_s),
		.out_valid(k_cmd_s_valid),
		.out_ready(k_cmd_s_ready)
	);

	cbuf_port_ctrl #(
		.is_kbuf(1'b1)
	) k_ctrl (
		.aclk(aclk),
		.rst_n(rst_n),
		.fmbufbankn(fmbufbankn),
		.cmd(k_cmd_s),
		.cmd_valid(k_cmd_s_valid),
		.cmd_ready(k_cmd_s_ready),
		.bank_req(k_bank_req),
		.bank_rdata(k_bank_rdata),
		.rsp(k_rsp_c),
		.rsp_valid(k_rsp_c_valid),
		.rsp_ready(k_rsp_c_ready)
	);

	icb_reg_slice #(
		.payload_t(icb_rsp_t)
	) k_rsp_slice (
		.aclk(aclk),
		.rst_n(rst_n),
		.in_data(k_rsp_c),
		.in_valid(k_rsp_c_valid),
		.in_ready(k_rsp_c_ready),
		.out_data(k_rsp),
		.out_valid(k_rsp_valid),
		.out_ready(k_rsp_ready)
	);

	cbuf_bank_array banks (
		.aclk(aclk),
		.fm_req(fm_bank_req),
		.k_req(k_bank_req),
		.fm_rdata(fm_bank_rdata),
		.k_rdata(k_bank_rdata)
	);

endmodule

/* hw/cbuf_bank_array.sv */
// SRAM bank pool with per-port request routing and registered read data
`timescale 1ns/1ns

module cbuf_bank_array import cbuf_pkg::*; (
	input  logic       aclk,

	input  bank_req_t  fm_req,
	input  bank_req_t  k_req,

	output cbuf_data_t fm_rdata,
	output cbuf_data_t k_rdata
);

	cbuf_data_t bank_dout [BANK_N];
	bank_idx_t fm_rd_bank; // bank each port touched last
	bank_idx_t k_rd_bank;

	for (genvar b = 0; b < BANK_N; b++) begin : g_bank
		cbuf_data_t mem [BANK_DEPTH];
		cbuf_data_t dout_q;
		bank_req_t req;

		// regions are disjoint, so at most one port hits this bank
		always_comb begin
			if (fm_req.en && fm_req.bank == bank_idx_t'(b))
				req = fm_req;
			else if (k_req.en && k_req.bank == bank_idx_t'(b))
				req = k_req;
			else
				req = '0;
		end

		always_ff @(posedge aclk) begin
			if (req.en) begin
				dout_q <= mem[req.row]; // read-first
				for (int i = 0; i < LANE_BYTES; i++) begin
					if (req.wen[i])
						mem[req.row][i*8 +: 8] <= req.wdata[i*8 +: 8];
				end
			end
		end

		assign bank_dout[b] = dout_q;
	end

	always_ff @(posedge aclk) begin
		if (fm_req.en)
			fm_rd_bank <= fm_req.bank;
		if (k_req.en)
			k_rd_bank <= k_req.bank;
	end

	assign fm_rdata = bank_dout[fm_rd_bank];
	assign k_rdata = bank_dout[k_rd_bank];

endmodule

/* hw/cbuf_port_ctrl.sv */
// per-region access controller with address mapping, bound check and response holding
`timescale 1ns/1ns

module cbuf_port_ctrl import cbuf_pkg::*; #(
	parameter bit is_kbuf = 1'b0 // 1 = kernel region, 0 = feature-map region
)(
	input  logic       aclk,
	input  logic       rst_n,

	input  bank_cnt_t  fmbufbankn, // banks given to the feature map

	// command from the register slice
	input  icb_cmd_t   cmd,
	input  logic       cmd_valid,
	output logic       cmd_ready,

	// bank array side
	output bank_req_t  bank_req,
	input  cbuf_data_t bank_rdata,

	// response toward the register slice
	output icb_rsp_t   rsp,
	output logic       rsp_valid,
	input  logic       rsp_ready
);

	localparam int LWORD_W = $bits(icb_addr_t) - WORD_ADDR_LSB;
	localparam int ROW_W = $bits(bank_row_t);

	logic [LWORD_W-1:0] lword; // logical word inside the region
	logic [LWORD_W-1:0] region_base;
	logic [LWORD_W-1:0] region_size;
	logic [LWORD_W-1:0] pword; // physical word over all banks
	logic in_bound;
	logic accept;

	// bank access in flight, result comes back next cycle
	logic s1_valid;
	logic s1_read;
	logic s1_err;

	icb_rsp_t rsp_q;
	logic rsp_valid_q;
	logic rsp_load;

	always_comb begin
		lword = cmd.addr[$bits(icb_addr_t)-1:WORD_ADDR_LSB];

		// kernel banks sit right after the feature-map banks
		region_base = is_kbuf ? LWORD_W'(fmbufbankn) * LWORD_W'(BANK_DEPTH) : '0;
		region_size = is_kbuf ? LWORD_W'(BANK_N - int'(fmbufbankn)) * LWORD_W'(BANK_DEPTH) :
			LWORD_W'(fmbufbankn) * LWORD_W'(BANK_DEPTH);

		in_bound = lword < region_size;
		pword = region_base + lword;
	end

	assign rsp_load = s1_valid & (~rsp_valid_q | rsp_ready);

	// no new access while the pending read data still waits in the bank register
	assign cmd_ready = ~s1_valid | rsp_load;
	assign accept = cmd_valid & cmd_ready;

	always_comb begin
		bank_req.en = accept & in_bound; // out of bounds never touches memory
		bank_req.wen = cmd.read ? '0 : cmd.wmask;
		bank_req.bank = pword[ROW_W +: $bits(bank_idx_t)];
		bank_req.row = pword[ROW_W-1:0];
		bank_req.wdata = cmd.wdata;
	end

	always_ff @(posedge aclk or negedge rst_n) begin
		if (!rst_n) begin
			s1_valid <= 1'b0;
			rsp_valid_q <= 1'b0;
		end else begin
			if (cmd_ready)
				s1_valid <= cmd_valid;
			if (rsp_load)
				rsp_valid_q <= 1'b1;
			else if (rsp_ready)
				rsp_valid_q <= 1'b0;
		end
	end

	always_ff @(posedge aclk) begin
		if (accept) begin
			s1_read <= cmd.read;
			s1_err <= ~in_bound;
		end
		if (rsp_load) begin
			rsp_q.rdata <= (s1_read && !s1_err) ? bank_rdata : '0; // writes and errors read 0
			rsp_q.err <= s1_err;
		end
	end

	assign rsp = rsp_q;
	assign rsp_valid = rsp_valid_q;

endmodule

/* hw/icb_reg_slice.sv */
// two-entry skid register slice for one valid/ready channel
`timescale 1ns/1ns

module icb_reg_slice import cbuf_pkg::*; #(
	parameter type payload_t = icb_cmd_t
)(
	input  logic     aclk,
	input  logic     rst_n,

	// upstream side
	input  payload_t in_data,
	input  logic     in_valid,
	output logic     in_ready,

	// downstream side
	output payload_t out_data,
	output logic     out_valid,
	input  logic     out_ready
);

	payload_t main_data; // drives the output
	logic main_valid;
	payload_t side_data; // catches the item taken while the output stalls
	logic side_valid;
	logic main_free;

	// main register can take a new item this cycle
	assign main_free = ~main_valid | out_ready;

	// ready only looks at a register, so no path from out_ready
	assign in_ready = ~side_valid;

	assign out_data = main_data;
	assign out_valid = main_valid;

	always_ff @(posedge aclk or negedge rst_n) begin
		if (!rst_n) begin
			main_valid <= 1'b0;
			side_valid <= 1'b0;
		end else if (main_free) begin
			main_valid <= side_valid | in_valid; // side entry drains first
			side_valid <= 1'b0;
		end else if (in_valid && in_ready) begin
			side_valid <= 1'b1;
		end
	end

	always_ff @(posedge aclk) begin
		if (main_free)
			main_data <= side_valid ? side_data : in_data;

		// output stalled, park the incoming item
		if (!main_free && in_valid && in_ready)
			side_data <= in_data;
	end

endmodule

/* hw/cbuf_pkg.sv */
// convolution buffer package with bank sizes, vector types and ICB channel structs
package cbuf_pkg;

	localparam int ATOMIC_C = 4; // channel parallelism
	localparam int LANE_BYTES = ATOMIC_C * 2; // two bytes per channel
	localparam int DATA_W = LANE_BYTES * 8;
	localparam int BANK_N = 8;
	localparam int BANK_DEPTH = 64; // rows per bank
	localparam int WORD_ADDR_LSB = $clog2(LANE_BYTES); // alignment bits, dropped

	// byte address on the ICB side
	typedef logic [31:0] icb_addr_t;

	// one buffer word and its byte mask
	typedef logic [DATA_W-1:0] cbuf_data_t;
	typedef logic [LANE_BYTES-1:0] cbuf_mask_t;

	// bank coordinates
	typedef logic [$clog2(BANK_N)-1:0] bank_idx_t;
	typedef logic [$clog2(BANK_DEPTH)-1:0] bank_row_t;

	// 0..BANK_N, needs one extra bit
	typedef logic [$clog2(BANK_N):0] bank_cnt_t;

	// command channel payload, 105 bits
	typedef struct packed {
		icb_addr_t addr;
		logic read; // 1 = read, 0 = masked write
		cbuf_data_t wdata;
		cbuf_mask_t wmask;
	} icb_cmd_t;

	// response channel payload, 65 bits
	typedef struct packed {
		cbuf_data_t rdata;
		logic err; // out of region
	} icb_rsp_t;

	// single bank access from one port controller
	typedef struct packed {
		logic en;
		cbuf_mask_t wen; // all zero for a read
		bank_idx_t bank;
		bank_row_t row;
		cbuf_data_t wdata;
	} bank_req_t;

endpackage
